/* hw/dcache_pkg.sv */
// shared cache types, line geometry and controller states, imported by each design module
package dcache_pkg;

	// ------------------------------
	// data and address widths
	// ------------------------------

	// one processor word
	typedef logic [31:0]  word_t;

	// processor word address, byte offset already dropped
	typedef logic [29:0]  word_addr_t;

	// one cache line, four words
	typedef logic [127:0] line_t;

	// memory line address, word offset dropped
	typedef logic [27:0]  line_addr_t;

	// ------------------------------
	// line geometry
	// ------------------------------

	// word-in-line select field
	localparam int WORD_SEL_W     = 2;
	localparam int WORDS_PER_LINE = 4;

	// ------------------------------
	// controller states
	// ------------------------------

	// compare is the resting state, idle only follows reset
	typedef enum logic [1:0] {
		ST_COMPARE    = 2'b00,
		ST_WRITE_BACK = 2'b01,
		ST_ALLOCATE   = 2'b10,
		ST_IDLE       = 2'b11
	} cache_state_e;

endpackage

/* hw/line_if.sv */
// command and read-back bundle between the cache controller and the line storage
`timescale 1ns/1ns
interface line_if import dcache_pkg::*; #(
	parameter int SET_BITS = 2
);
	localparam int TAG_W = $bits(line_addr_t) - SET_BITS;

	// set being looked at, read back combinationally
	logic [SET_BITS-1:0]   set_idx;

	// refill of a whole line from memory
	logic                  fill_en;
	logic                  fill_way;
	logic [TAG_W-1:0]      fill_tag;
	line_t                 fill_data;

	// single word write on a write hit
	logic                  wr_en;
	logic                  wr_way;
	logic [WORD_SEL_W-1:0] wr_word;
	word_t                 wr_data;

	// dirty clear after write-back
	logic                  clean_en;
	logic                  clean_way;

	// lru update, points away from touch_way
	logic                  touch_en;
	logic                  touch_way;

	// addressed set, both ways
	logic [TAG_W-1:0]      tag0, tag1;
	logic                  valid0, valid1;
	logic                  dirty0, dirty1;
	line_t                 data0, data1;
	// way to replace next
	logic                  lru;

	modport ctrl (
		output set_idx, fill_en, fill_way, fill_tag, fill_data,
		output wr_en, wr_way, wr_word, wr_data,
		output clean_en, clean_way, touch_en, touch_way,
		input  tag0, tag1, valid0, valid1, dirty0, dirty1, data0, data1, lru
	);

	modport store (
		input  set_idx, fill_en, fill_way, fill_tag, fill_data,
		input  wr_en, wr_way, wr_word, wr_data,
		input  clean_en, clean_way, touch_en, touch_way,
		output tag0, tag1, valid0, valid1, dirty0, dirty1, data0, data1, lru
	);

endinterface

/* hw/line_store.sv */
// two-way line storage with per-set lru, read at set_idx and updated on the clock edge
`timescale 1ns/1ns
module line_store import dcache_pkg::*; #(
	parameter int SET_BITS = 2
) (
	input  logic  clk,
	input  logic  proc_reset,
	line_if.store lines
);
	localparam int TAG_W    = $bits(line_addr_t) - SET_BITS;
	localparam int NUM_SETS = 1 << SET_BITS;
	localparam int WORD_W   = $bits(word_t);

	// ------------------------------
	// arrays, first index is the way
	// ------------------------------

	logic [TAG_W-1:0]    tag_q   [2][NUM_SETS];
	line_t               data_q  [2][NUM_SETS];
	logic [NUM_SETS-1:0] valid_q [2];
	logic [NUM_SETS-1:0] dirty_q [2];
	// one bit per set, names the victim way
	logic [NUM_SETS-1:0] lru_q;

	// ------------------------------
	// read side
	// ------------------------------

	assign lines.tag0   = tag_q[0][lines.set_idx];
	assign lines.tag1   = tag_q[1][lines.set_idx];
	assign lines.data0  = data_q[0][lines.set_idx];
	assign lines.data1  = data_q[1][lines.set_idx];
	assign lines.valid0 = valid_q[0][lines.set_idx];
	assign lines.valid1 = valid_q[1][lines.set_idx];
	assign lines.dirty0 = dirty_q[0][lines.set_idx];
	assign lines.dirty1 = dirty_q[1][lines.set_idx];
	assign lines.lru    = lru_q[lines.set_idx];

	// ------------------------------
	// status bits
	// ------------------------------

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			// every line invalid and clean
			valid_q[0] <= '0;
			valid_q[1] <= '0;
			dirty_q[0] <= '0;
			dirty_q[1] <= '0;
			lru_q      <= '0;
		end else begin
			// refilled line is valid and clean
			if (lines.fill_en) begin
				valid_q[lines.fill_way][lines.set_idx] <= 1'b1;
				dirty_q[lines.fill_way][lines.set_idx] <= 1'b0;
			end
			if (lines.wr_en) begin
				dirty_q[lines.wr_way][lines.set_idx] <= 1'b1;
			end
			if (lines.clean_en) begin
				dirty_q[lines.clean_way][lines.set_idx] <= 1'b0;
			end
			// next victim is the other way
			if (lines.touch_en) begin
				lru_q[lines.set_idx] <= ~lines.touch_way;
			end
		end
	end

	// ------------------------------
	// tags and line data
	// ------------------------------

	always_ff @(posedge clk) begin
		if (lines.fill_en) begin
			tag_q[lines.fill_way][lines.set_idx]  <= lines.fill_tag;
			data_q[lines.fill_way][lines.set_idx] <= lines.fill_data;
		end
		// word write lands in the hitting way only
		if (lines.wr_en) begin
			data_q[lines.wr_way][lines.set_idx][lines.wr_word*WORD_W +: WORD_W] <= lines.wr_data;
		end
	end

endmodule

/* hw/dcache_ctrl.sv */
// cache controller: hit check, word select, stall and the write-back/refill FSM toward memory
`timescale 1ns/1ns
module dcache_ctrl import dcache_pkg::*; #(
	parameter int SET_BITS = 2
) (
	input  logic       clk,
	input  logic       proc_reset,
	input  logic       proc_read,
	input  logic       proc_write,
	input  word_addr_t proc_addr,
	input  word_t      proc_wdata,
	output word_t      proc_rdata,
	output logic       proc_stall,
	output logic       mem_read,
	output logic       mem_write,
	output line_addr_t mem_addr,
	output line_t      mem_wdata,
	input  line_t      mem_rdata,
	input  logic       mem_ready,
	line_if.ctrl       store
);
	localparam int TAG_W = $bits(line_addr_t) - SET_BITS;

	// current and next controller state
	cache_state_e state, state_nxt;

	// ------------------------------
	// request fields
	// ------------------------------

	logic [TAG_W-1:0]      req_tag;
	logic [SET_BITS-1:0]   req_set;
	logic [WORD_SEL_W-1:0] req_word;
	logic                  req;

	assign req_word = proc_addr[WORD_SEL_W-1:0];
	assign req_set  = proc_addr[WORD_SEL_W +: SET_BITS];
	assign req_tag  = proc_addr[$bits(word_addr_t)-1 -: TAG_W];
	assign req      = proc_read | proc_write;

	// ------------------------------
	// hit check and victim
	// ------------------------------

	logic                  hit0, hit1, hit, hit_way;
	logic                  victim_way, victim_dirty;
	logic [TAG_W-1:0]      victim_tag;
	word_t [WORDS_PER_LINE-1:0] hit_words;

	assign hit0    = store.valid0 & (store.tag0 == req_tag);
	assign hit1    = store.valid1 & (store.tag1 == req_tag);
	assign hit     = hit0 | hit1;
	assign hit_way = hit1;

	// victim is whatever lru names, dirty or not
	assign victim_way   = store.lru;
	assign victim_dirty = victim_way ? store.dirty1 : store.dirty0;
	assign victim_tag   = victim_way ? store.tag1 : store.tag0;

	// word view of the hitting line
	assign hit_words  = hit_way ? store.data1 : store.data0;
	assign proc_rdata = hit_words[req_word];

	// ------------------------------
	// memory side and store commands
	// ------------------------------

	// write-back goes to the victim's own address
	assign mem_addr  = (state == ST_WRITE_BACK) ? {victim_tag, req_set} :
		proc_addr[$bits(word_addr_t)-1:WORD_SEL_W];
	assign mem_wdata = victim_way ? store.data1 : store.data0;

	assign store.set_idx   = req_set;
	assign store.wr_way    = hit_way;
	assign store.wr_word   = req_word;
	assign store.wr_data   = proc_wdata;
	assign store.fill_way  = victim_way;
	assign store.fill_tag  = req_tag;
	assign store.fill_data = mem_rdata;
	assign store.clean_way = victim_way;

	// ------------------------------
	// FSM
	// ------------------------------

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt       = state;
		proc_stall      = 1'b1;
		mem_read        = 1'b0;
		mem_write       = 1'b0;
		store.wr_en     = 1'b0;
		store.fill_en   = 1'b0;
		store.clean_en  = 1'b0;
		store.touch_en  = 1'b0;
		store.touch_way = hit_way;
		case (state)
			ST_COMPARE: begin
				// hit completes with no stall
				proc_stall = req & ~hit;
				if (req & hit) begin
					store.touch_en = 1'b1;
					store.wr_en    = proc_write;
				end else if (req) begin
					state_nxt = victim_dirty ? ST_WRITE_BACK : ST_ALLOCATE;
				end
			end
			ST_WRITE_BACK: begin
				mem_write = 1'b1;
				if (mem_ready) begin
					store.clean_en = 1'b1;
					state_nxt      = ST_ALLOCATE;
				end
			end
			ST_ALLOCATE: begin
				mem_read = 1'b1;
				// refill lands in the victim way, lru flips to the other
				if (mem_ready) begin
					store.fill_en   = 1'b1;
					store.touch_en  = 1'b1;
					store.touch_way = victim_way;
					state_nxt       = ST_COMPARE;
				end
			end
			ST_IDLE: begin
				state_nxt = ST_COMPARE;
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

endmodule

/* hw/dcache_top.sv */
// data cache top level, plain processor and memory ports around controller and line storage
`timescale 1ns/1ns
module dcache_top import dcache_pkg::*; #(
	// 2 gives four sets
	parameter int SET_BITS = 2
) (
	input  logic       clk,
	input  logic       proc_reset,
	// processor word port
	input  logic       proc_read,
	input  logic       proc_write,
	input  word_addr_t proc_addr,
	input  word_t      proc_wdata,
	output word_t      proc_rdata,
	output logic       proc_stall,
	// memory line port
	output logic       mem_read,
	output logic       mem_write,
	output line_addr_t mem_addr,
	output line_t      mem_wdata,
	input  line_t      mem_rdata,
	input  logic       mem_ready
);

	// ------------------------------
	// controller to storage bundle
	// ------------------------------

	line_if #(.SET_BITS(SET_BITS)) lines_bus ();

	dcache_ctrl #(.SET_BITS(SET_BITS)) ctrl_inst (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready),
		.store      (lines_bus.ctrl)
	);

	// tag, status and data arrays
	line_store #(.SET_BITS(SET_BITS)) store_inst (
		.clk        (clk),
		.proc_reset (proc_reset),
		.lines      (lines_bus.store)
	);

endmodule

/* tb/dcache_chk.sv */
// concurrent checks on the cache memory handshake, bound into the cache top level
`timescale 1ns/1ns
module dcache_chk import dcache_pkg::*; (
	input logic       clk,
	input logic       proc_reset,
	input logic       mem_read,
	input logic       mem_write,
	input line_addr_t mem_addr,
	input line_t      mem_wdata,
	input logic       mem_ready
);

	// ------------------------------
	// memory handshake
	// ------------------------------

	// one direction at a time
	read_write_excl: assert property (@(posedge clk) !(mem_read && mem_write))
		else $error("mem_read and mem_write high together");

	// address held until ready
	addr_held: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read || mem_write) && !mem_ready |=> $stable(mem_addr))
		else $error("mem_addr changed while a request waited");

	// write data held for the whole write
	wdata_held: assert property (@(posedge clk) disable iff (proc_reset)
		mem_write && !mem_ready |=> $stable(mem_wdata))
		else $error("mem_wdata changed during a write");

	// quiet bus in reset
	quiet_in_reset: assert property (@(posedge clk) proc_reset |-> !(mem_read || mem_write))
		else $error("memory request during reset");

endmodule

/* tb/tb_dcache.sv */
// testbench for the data cache: memory model, shadow reference, directed and random accesses
`timescale 1ns/1ns
module tb_dcache import dcache_pkg::*; ();
	localparam int TIMEOUT = 200;
	localparam int LINES   = 64;

	logic       clk;
	logic       proc_reset;
	logic       proc_read;
	logic       proc_write;
	logic       proc_stall;
	logic       mem_read;
	logic       mem_write;
	logic       mem_ready;
	word_addr_t proc_addr;
	word_t      proc_wdata;
	word_t      proc_rdata;
	line_addr_t mem_addr;
	line_t      mem_wdata;
	line_t      mem_rdata;

	// memory lines, shadow words and write-back tracking per line
	line_t      mem_lines [LINES];
	word_t      shadow [LINES*WORDS_PER_LINE];
	logic       wb_seen [LINES];
	logic       dirty_since_wb [LINES];
	// memory requests, write flag above the line address
	logic [28:0] req_log [$];
	word_t       got_q [$];
	word_t       exp_q [$];

	dcache_top #(.SET_BITS(2)) dcache_top_inst (
		.clk(clk), .proc_reset(proc_reset), .proc_read(proc_read), .proc_write(proc_write),
		.proc_addr(proc_addr), .proc_wdata(proc_wdata), .proc_rdata(proc_rdata),
		.proc_stall(proc_stall), .mem_read(mem_read), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ready(mem_ready)
	);

	bind dcache_top dcache_chk chk_inst (.clk(clk), .proc_reset(proc_reset),
		.mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ready(mem_ready));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ------------------------------
	// reference and helpers
	// ------------------------------

	// initial memory contents, spread over the whole word address
	function automatic word_t pattern_word(input int a);
		return (32'(a) * 32'h9e3779b1) ^ 32'h5ac30f96;
	endfunction

	function automatic word_t expected_word(input word_addr_t a);
		return shadow[a[7:0]];
	endfunction

	function automatic line_t shadow_line(input logic [5:0] la);
		line_t l;
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			l[w*32 +: 32] = shadow[{la, 2'(w)}];
		end
		return l;
	endfunction

	// tag, set and word fields of a word address
	function automatic word_addr_t make_addr(input int tag, input int set, input int word);
		return word_addr_t'((tag << 4) | (set << 2) | word);
	endfunction

	function automatic logic [28:0] mem_req(input logic wr, input word_addr_t a);
		return {wr, a[29:2]};
	endfunction

	task automatic abort_run(input string why);
		$display("%s at t=%0t", why, $time);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input line_t got, input line_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
			abort_run("value mismatch");
		end
	endtask

	// one processor request, held until an edge with stall low
	task automatic do_access(input logic wr, input word_addr_t addr, input word_t wdata,
			output int stalls);
		stalls = 0;
		proc_read = ~wr;
		proc_write = wr;
		proc_addr = addr;
		proc_wdata = wdata;
		#10;
		while (proc_stall) begin
			if (stalls == TIMEOUT) abort_run("timeout waiting for proc_stall low");
			@(negedge clk);
			#10;
			stalls++;
		end
		// completes at the coming rising edge
		if (wr) begin
			shadow[addr[7:0]] = wdata;
			dirty_since_wb[addr[7:2]] = 1'b1;
		end else begin
			got_q.push_back(proc_rdata);
			exp_q.push_back(expected_word(addr));
		end
		@(negedge clk);
		proc_read = 1'b0;
		proc_write = 1'b0;
	endtask

	// ------------------------------
	// memory model and read compare
	// ------------------------------

	initial begin : memory_model
		int         delay;
		logic [5:0] idx;
		mem_ready = 1'b0;
		mem_rdata = '0;
		forever begin
			@(negedge clk);
			if (mem_read || mem_write) begin
				if (mem_addr >= LINES) abort_run("memory request outside the modelled lines");
				idx = mem_addr[5:0];
				req_log.push_back({mem_write, mem_addr});
				delay = $urandom_range(5, 1);
				repeat (delay - 1) @(negedge clk);
				// write-back replaces the stored line
				if (mem_write) begin
					mem_lines[idx] = mem_wdata;
					wb_seen[idx] = 1'b1;
					dirty_since_wb[idx] = 1'b0;
				end else begin
					mem_rdata = mem_lines[idx];
				end
				mem_ready = 1'b1;
				@(negedge clk);
				mem_ready = 1'b0;
			end
		end
	end

	initial begin : compare_reads
		forever begin
			@(negedge clk);
			while (got_q.size() > 0) begin
				check_value("proc_rdata", line_t'(got_q.pop_front()), line_t'(exp_q.pop_front()));
			end
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------

	initial begin : stimulus
		int         stalls;
		word_addr_t addr;
		void'($urandom(32'haee2));
		proc_reset = 1'b1;
		proc_read = 1'b0;
		proc_write = 1'b0;
		proc_addr = '0;
		proc_wdata = '0;
		for (int a = 0; a < LINES*WORDS_PER_LINE; a++) shadow[8'(a)] = pattern_word(a);
		for (int l = 0; l < LINES; l++) begin
			mem_lines[6'(l)] = shadow_line(6'(l));
			wb_seen[6'(l)] = 1'b0;
			dirty_since_wb[6'(l)] = 1'b0;
		end
		repeat (16) @(negedge clk);
		proc_reset = 1'b0;

		// cold read miss, then a same-line hit and a write hit in set 0
		do_access(1'b0, make_addr(0, 0, 1), '0, stalls);
		check_value("mem request count", line_t'(req_log.size()), line_t'(1));
		check_value("mem request", line_t'(req_log[0]), line_t'(mem_req(1'b0, make_addr(0, 0, 1))));
		req_log.delete();
		do_access(1'b0, make_addr(0, 0, 3), '0, stalls);
		check_value("proc_stall cycles", line_t'(stalls), line_t'(0));
		do_access(1'b1, make_addr(0, 0, 2), $urandom, stalls);
		do_access(1'b0, make_addr(0, 0, 2), '0, stalls);
		check_value("mem request count", line_t'(req_log.size()), line_t'(0));

		// dirty victim in set 1 goes out before the refill
		do_access(1'b1, make_addr(1, 1, 0), $urandom, stalls);
		do_access(1'b0, make_addr(2, 1, 0), '0, stalls);
		req_log.delete();
		do_access(1'b0, make_addr(3, 1, 0), '0, stalls);
		check_value("mem request count", line_t'(req_log.size()), line_t'(2));
		check_value("mem request", line_t'(req_log[0]), line_t'(mem_req(1'b1, make_addr(1, 1, 0))));
		check_value("mem request", line_t'(req_log[1]), line_t'(mem_req(1'b0, make_addr(3, 1, 0))));
		// written-back line carries the earlier write
		addr = make_addr(1, 1, 0);
		check_value("mem_wdata", mem_lines[addr[7:2]], shadow_line(addr[7:2]));

		// lru in set 2, re-read A so C evicts B
		do_access(1'b0, make_addr(4, 2, 1), '0, stalls);
		do_access(1'b0, make_addr(5, 2, 1), '0, stalls);
		do_access(1'b0, make_addr(4, 2, 1), '0, stalls);
		do_access(1'b0, make_addr(6, 2, 1), '0, stalls);
		req_log.delete();
		do_access(1'b0, make_addr(4, 2, 1), '0, stalls);
		check_value("mem request count", line_t'(req_log.size()), line_t'(0));
		do_access(1'b0, make_addr(5, 2, 1), '0, stalls);
		check_value("mem request count", line_t'(req_log.size()), line_t'(1));
		check_value("mem request", line_t'(req_log[0]), line_t'(mem_req(1'b0, make_addr(5, 2, 1))));

		// random mix over eight tags and all sets
		for (int i = 0; i < 300; i++) begin
			addr = make_addr($urandom_range(7, 0), $urandom_range(3, 0), $urandom_range(3, 0));
			do_access(1'($urandom_range(1, 0)), addr, $urandom, stalls);
		end
		stalls = 0;
		while (got_q.size() != 0) begin
			if (stalls == TIMEOUT) abort_run("timeout waiting for read compares");
			@(negedge clk);
			stalls++;
		end
		// lines not rewritten since their last write-back
		for (int l = 0; l < LINES; l++) begin
			if (wb_seen[6'(l)] && !dirty_since_wb[6'(l)]) begin
				check_value("memory line", mem_lines[6'(l)], shadow_line(6'(l)));
			end
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* compile.f */
hw/dcache_pkg.sv
hw/line_if.sv
hw/line_store.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tb/dcache_chk.sv
tb/tb_dcache.sv

/* run.sh */
#!/usr/bin/env bash
# builds the data cache testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_dcache -f compile.f
./obj_dir/Vtb_dcache > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation ok"
